// ==== pipeCore.f ====
verilog/pipePkg.sv
verilog/pipeIfs.sv
verilog/hazardCtrl.sv
verilog/fetchUnit.sv
verilog/instQueue.sv
verilog/execUnit.sv
verilog/pipeCore.sv
testbench/pipeCoreTb.sv

// ==== testbench/pipeCoreTb.sv ====
module pipeCoreTb import pipePkg::*; ();

    localparam int numTests = 6;
    localparam int instPerTest = 60;
    localparam int cyclesPerInst = 40;
    localparam int resetCycles = 8;
    localparam int cycleLimit = numTests * (instPerTest * cyclesPerInst + resetCycles);
    localparam int maxRecords = 4 * instPerTest;        // Bounds the model on trap-heavy code.
    localparam int progWords = 256;

    typedef struct packed {
        logic trap;
        logic [pcWidth-1:0] pc;
        logic [regIdxWidth-1:0] rd;
        logic [xlen-1:0] data;
        logic we;
    } retireRec;

    logic clk = 1'b0;
    logic rstN;
    logic imemReq;
    logic [pcWidth-1:0] imemAddr;
    logic imemValid;
    logic [instWidth-1:0] imemData;
    logic dmemReq;
    logic [xlen-1:0] dmemAddr;
    logic dmemValid;
    logic [xlen-1:0] dmemData;
    logic dmemErr;
    logic retireValid;
    logic [pcWidth-1:0] retirePc;
    logic [regIdxWidth-1:0] retireRd;
    logic [xlen-1:0] retireData;
    logic retireWe;
    logic trapTaken;

    logic [instWidth-1:0] prog [progWords];
    retireRec expQ [$];
    logic [31:0] lfsr;
    logic running;
    logic seenReq;                                      // First strobe after reset seen.
    logic abortTest;
    logic burstFetch;                                   // Fetch delay is 0 or 7 only.
    logic iBusy;
    logic dBusy;
    logic [pcWidth-1:0] iAddr;
    logic [xlen-1:0] dAddr;
    int iDelay;
    int dDelay;
    int retired;
    int errorCount;
    int failedTests;
    int cycleCount = 0;

    always #20 clk = ~clk;

    pipeCore i_dut (.*);

    ////////////////////////////////////////////////////////////////////////////
    // Random source, one step per bit
    ////////////////////////////////////////////////////////////////////////////
    function automatic logic nextBit();
        logic out;
        out = lfsr[0];
        lfsr = (lfsr >> 1) ^ (out ? 32'h8020_0003 : 32'h0);
        return out;
    endfunction

    function automatic logic [31:0] randBits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[30:0], nextBit()};
        end
        return r;
    endfunction

    function automatic string kindName(input int kind);
        case (kind)
            0: return "alu";
            1: return "mul";
            2: return "load";
            3: return "branch";
            4: return "trap";
            default: return "mixed";
        endcase
    endfunction

    function automatic logic [instWidth-1:0] makeInst(input int kind);
        logic [3:0] op;
        logic [2:0] rd;
        logic [2:0] rs;
        logic [5:0] imm;
        logic [1:0] pick;
        int k;
        k = kind;
        if (k == 5) begin
            k = 1 + int'(randBits(2));                  // Mixed draws one of the others.
        end
        rd = 3'(randBits(3));
        rs = 3'(randBits(3));
        imm = 6'(randBits(6));
        pick = 2'(randBits(2));
        op = pick[0] ? opAdd : opAddi;
        case (k)
            1: if (pick != 2'd0) op = opMul;
            2: if (pick[1]) op = opLoad;
            3: if (pick[1]) op = opBeqz;
            4: if (pick == 2'd3) op = 4'(randBits(4)); else if (pick == 2'd2) op = opLoad;
            default: ;
        endcase
        if (op == opBeqz) begin
            return {op, rd, {4{imm[4]}}, imm[4:0]};     // Short signed offset.
        end
        return {op, rd, rs, imm};
    endfunction

    task automatic loadProgram(input int kind);
        for (int a = 0; a < progWords; a++) begin
            if (a >= int'(trapVector) && a < int'(trapVector) + 16) begin
                prog[a] = makeInst(0);                  // Trap handler never traps.
            end else begin
                prog[a] = makeInst(kind);
            end
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Sequential ISA model, fills the expected retire records
    ////////////////////////////////////////////////////////////////////////////
    task automatic buildExpected();
        logic [xlen-1:0] regs [regCount];
        logic [pcWidth-1:0] pc;
        logic [instWidth-1:0] inst;
        logic [xlen-1:0] a;
        logic [xlen-1:0] b;
        logic [xlen-1:0] sum;
        int retires;
        expQ.delete();
        foreach (regs[i]) regs[i] = '0;
        pc = '0;
        retires = 0;
        while (retires < instPerTest && expQ.size() < maxRecords) begin
            inst = prog[pc[7:0]];
            a = regs[inst[8:6]];
            b = regs[inst[2:0]];
            sum = a + {{10{inst[5]}}, inst[5:0]};
            case (inst[15:12])
                opAddi, opAdd, opMul: begin
                    if (inst[15:12] == opAdd) sum = a + b;
                    if (inst[15:12] == opMul) sum = a * b;  // Low 16 bits.
                    expQ.push_back({1'b0, pc, inst[11:9], sum, 1'b1});
                    regs[inst[11:9]] = sum;
                    pc = pc + 16'd1;
                    retires++;
                end
                opLoad: begin
                    if (sum[15:12] == 4'hF) begin
                        expQ.push_back({1'b1, pc, 3'd0, 16'd0, 1'b0});
                        pc = trapVector;
                    end else begin
                        expQ.push_back({1'b0, pc, inst[11:9], sum ^ 16'h5A5A, 1'b1});
                        regs[inst[11:9]] = sum ^ 16'h5A5A;
                        pc = pc + 16'd1;
                        retires++;
                    end
                end
                opBeqz: begin
                    expQ.push_back({1'b0, pc, 3'd0, 16'd0, 1'b0});
                    retires++;
                    if (regs[inst[11:9]] == '0) begin
                        pc = pc + 16'd1 + {{7{inst[8]}}, inst[8:0]};
                    end else begin
                        pc = pc + 16'd1;
                    end
                end
                default: begin
                    expQ.push_back({1'b1, pc, 3'd0, 16'd0, 1'b0});  // Illegal opcode.
                    pc = trapVector;
                end
            endcase
        end
    endtask

    task automatic reportMismatch(input string sig, input logic [15:0] got,
                                  input logic [15:0] exp);
        $display("[ERROR] %s got %h expected %h", sig, got, exp);
        errorCount++;
    endtask

    task automatic reportFailure(input string msg);
        $display("%s", msg);
        errorCount++;
    endtask

    task automatic compareEvent();
        retireRec rec;
        if (expQ.size() == 0) begin
            reportFailure($sformatf("Event at pc %h after the model ran out of records", retirePc));
            abortTest = 1'b1;
        end else begin
            rec = expQ.pop_front();
            if (trapTaken && !rec.trap) begin
                reportFailure($sformatf("Trap taken where pc %h should have retired", rec.pc));
            end else if (retireValid && rec.trap) begin
                reportFailure($sformatf("Pc %h retired where pc %h should trap", retirePc, rec.pc));
                retired++;
            end else if (retireValid) begin
                retired++;
                if (retirePc !== rec.pc) reportMismatch("retirePc", retirePc, rec.pc);
                if (retireWe !== rec.we) reportMismatch("retireWe", retireWe, rec.we);
                if (rec.we && retireRd !== rec.rd) reportMismatch("retireRd", retireRd, rec.rd);
                if (rec.we && retireData !== rec.data) begin
                    reportMismatch("retireData", retireData, rec.data);
                end
            end
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Memory ports, requests taken at the rising edge, answers on the falling
    ////////////////////////////////////////////////////////////////////////////
    always @(posedge clk) begin
        if (rstN && imemReq) begin
            if (iBusy) reportFailure("Fetch request issued while another was outstanding");
            iBusy = 1'b1;
            iAddr = imemAddr;
            iDelay = burstFetch ? (randBits(1) ? 7 : 0) : int'(randBits(3));
        end
        if (rstN && dmemReq) begin
            if (dBusy) reportFailure("Load request issued while another was outstanding");
            dBusy = 1'b1;
            dAddr = dmemAddr;
            dDelay = int'(randBits(3));
        end
    end

    always @(negedge clk) begin
        imemValid = 1'b0;
        dmemValid = 1'b0;
        dmemErr = 1'b0;
        if (!rstN) begin
            iBusy = 1'b0;
            dBusy = 1'b0;
        end
        if (iBusy && iDelay == 0) begin
            imemValid = 1'b1;
            imemData = prog[iAddr[7:0]];
            iBusy = 1'b0;
        end else if (iBusy) begin
            iDelay--;
        end
        if (dBusy && dDelay == 0) begin
            dmemValid = 1'b1;
            dmemData = dAddr ^ 16'h5A5A;                // Data follows the address.
            dmemErr = (dAddr[15:12] == 4'hF);
            dBusy = 1'b0;
        end else if (dBusy) begin
            dDelay--;
        end
    end

    // Retire and trap monitor.
    always @(posedge clk) begin
        if (running) begin
            if (!seenReq && (imemReq || dmemReq)) begin
                seenReq = 1'b1;
                if (!imemReq) reportFailure("Load request issued before the first fetch");
                else if (imemAddr !== '0) reportMismatch("imemAddr", imemAddr, 16'h0000);
            end
            if (retireValid && trapTaken) begin
                reportFailure($sformatf("Retire and trap in one cycle at pc %h", retirePc));
            end else if (retireValid || trapTaken) begin
                compareEvent();
            end
        end
    end

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount >= cycleLimit) begin
            $display("Run stopped after %0d cycles with tests unfinished", cycleCount);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    task automatic runTest(input int kind);
        int errsBefore;
        @(negedge clk);
        rstN = 1'b0;
        running = 1'b0;
        burstFetch = (kind == 1);                       // Fills the queue behind multiplies.
        loadProgram(kind);
        buildExpected();
        repeat (resetCycles) @(negedge clk);
        errsBefore = errorCount;
        seenReq = 1'b0;
        abortTest = 1'b0;
        retired = 0;
        rstN = 1'b1;
        running = 1'b1;
        while (retired < instPerTest && !abortTest) begin
            @(negedge clk);
        end
        running = 1'b0;
        if (errorCount != errsBefore) failedTests++;
        $display("Test %0d %s: %0d retired, %0d errors", kind, kindName(kind), retired,
                 errorCount - errsBefore);
    endtask

    initial begin
        rstN = 1'b0;
        imemValid = 1'b0;
        imemData = '0;
        dmemValid = 1'b0;
        dmemData = '0;
        dmemErr = 1'b0;
        lfsr = 32'ha327_4b3a;
        running = 1'b0;
        iBusy = 1'b0;
        dBusy = 1'b0;
        burstFetch = 1'b0;
        errorCount = 0;
        failedTests = 0;
        for (int t = 0; t < numTests; t++) begin
            runTest(t);
        end
        $display("Tests run %0d, tests failed %0d, errors %0d", numTests, failedTests, errorCount);
        if (errorCount == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end
endmodule

// ==== verilog/execUnit.sv ====
module execUnit import pipePkg::*; (
    input logic clk,
    input logic rstN,
    hazardIf.exec hz,
    queueIf.consumer q,
    output logic [pcWidth-1:0] redirectPc,
    output logic dmemReq,
    output logic [xlen-1:0] dmemAddr,
    input logic dmemValid,
    input logic [xlen-1:0] dmemData,
    input logic dmemErr,
    output logic retireValid,
    output logic [pcWidth-1:0] retirePc,
    output logic [regIdxWidth-1:0] retireRd,
    output logic [xlen-1:0] retireData,
    output logic retireWe,
    output logic trapTaken
);
    logic [xlen-1:0] regFile [regCount];

    logic dValid;
    queueEntry dEntry;
    logic issue;

    logic eValid;
    logic [pcWidth-1:0] ePc;
    instWord eInst;
    logic [xlen-1:0] eA;
    logic [xlen-1:0] eB;
    logic [xlen-1:0] eResult;
    logic [mulCntWidth-1:0] mulCnt;                     // Multiply cycles left.

    logic mValid;
    logic mReqSent;
    logic [pcWidth-1:0] mPc;
    instWord mInst;
    logic [xlen-1:0] mA;
    logic [xlen-1:0] mResult;
    logic mIsLoad;
    logic mWrites;
    logic mDone;

    logic wValid;
    logic wErr;
    logic wWe;
    logic [pcWidth-1:0] wPc;
    logic [regIdxWidth-1:0] wRd;
    logic [xlen-1:0] wData;

    ////////////////////////////////////////////////////////////////////////////
    // D stage, one instruction in flight past D
    ////////////////////////////////////////////////////////////////////////////
    assign issue = dValid && !hz.stallD && !eValid && !mValid && !wValid;
    assign q.pop = !q.empty && (!dValid || issue) && !hz.stallD && !hz.flushD;

    ////////////////////////////////////////////////////////////////////////////
    // E stage
    ////////////////////////////////////////////////////////////////////////////
    always_comb begin
        case (eInst.alu.opcode)
            opAddi, opLoad: eResult = eA + {{(xlen - 6){eInst.alu.imm[5]}}, eInst.alu.imm};
            opAdd: eResult = eA + eB;
            opMul: eResult = eA * eB;                   // Low half kept.
            default: eResult = '0;
        endcase
    end

    assign hz.eWait = eValid && (mulCnt != '0);

    ////////////////////////////////////////////////////////////////////////////
    // M stage, branch, illegal opcode and load request
    ////////////////////////////////////////////////////////////////////////////
    assign mIsLoad = (mInst.alu.opcode == opLoad);
    assign mWrites = (mInst.alu.opcode == opAddi) || (mInst.alu.opcode == opAdd)
                     || (mInst.alu.opcode == opMul) || mIsLoad;
    assign mDone = !mIsLoad || dmemValid;

    assign hz.branchM = mValid && (mInst.br.opcode == opBeqz) && (mA == '0);
    assign hz.excpM = mValid && !mWrites && (mInst.br.opcode != opBeqz);
    assign hz.dWait = mValid && mIsLoad && !dmemValid;
    assign hz.excpW = wValid && wErr;

    assign dmemReq = mValid && mIsLoad && !mReqSent;
    assign dmemAddr = mResult;

    assign redirectPc = (hz.excpM || hz.excpW) ? trapVector
                      : mPc + pcWidth'(1) + {{(pcWidth - 9){mInst.br.offset[8]}}, mInst.br.offset};

    // W stage drives the retire port.
    assign retireValid = wValid && !wErr;
    assign retirePc = wPc;
    assign retireRd = wRd;
    assign retireData = wData;
    assign retireWe = wWe;
    assign trapTaken = hz.excpM || hz.excpW;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            dValid <= 1'b0;
            eValid <= 1'b0;
            mulCnt <= '0;
            mValid <= 1'b0;
            mReqSent <= 1'b0;
            wValid <= 1'b0;
        end else begin
            if (hz.flushD) begin
                dValid <= 1'b0;
            end else if (q.pop) begin
                dValid <= 1'b1;
            end else if (issue) begin
                dValid <= 1'b0;
            end

            if (hz.flushE) begin
                eValid <= 1'b0;
                mulCnt <= '0;
            end else if (hz.stallE) begin
                if (mulCnt != '0) begin
                    mulCnt <= mulCnt - mulCntWidth'(1);
                end
            end else begin
                eValid <= issue;
                mulCnt <= (issue && dEntry.inst.alu.opcode == opMul)
                          ? mulCntWidth'(mulLatency - 1) : '0;
            end

            if (hz.flushM) begin
                mValid <= 1'b0;
                mReqSent <= 1'b0;
            end else if (hz.dWait) begin
                mReqSent <= 1'b1;                       // Load waits in M.
            end else begin
                mValid <= eValid;
                mReqSent <= 1'b0;
            end

            wValid <= mValid && mDone && !hz.excpM && !hz.flushW;
        end
    end

    always_ff @(posedge clk) begin
        if (q.pop) begin
            dEntry <= q.popEntry;
        end
        if (issue) begin
            ePc <= dEntry.pc;
            eInst <= dEntry.inst;
            // BEQZ keeps rs where the ALU format has rd.
            eA <= regFile[(dEntry.inst.br.opcode == opBeqz) ? dEntry.inst.br.rs
                                                            : dEntry.inst.alu.rs];
            eB <= regFile[dEntry.inst.alu.imm[regIdxWidth-1:0]];
        end
        if (!hz.dWait) begin
            mPc <= ePc;
            mInst <= eInst;
            mA <= eA;
            mResult <= eResult;
        end
        wPc <= mPc;
        wRd <= mWrites ? mInst.alu.rd : '0;
        wData <= mIsLoad ? dmemData : mResult;
        wWe <= mWrites;
        wErr <= mIsLoad && dmemErr;
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < regCount; i++) begin
                regFile[i] <= '0;
            end
        end else if (retireValid && wWe) begin
            regFile[wRd] <= wData;
        end
    end
endmodule

// ==== verilog/fetchUnit.sv ====
module fetchUnit import pipePkg::*; (
    input logic clk,
    input logic rstN,
    hazardIf.fetch hz,
    queueIf.producer q,
    input logic [pcWidth-1:0] redirectPc,
    output logic imemReq,
    output logic [pcWidth-1:0] imemAddr,
    input logic imemValid,
    input logic [instWidth-1:0] imemData
);
    logic [pcWidth-1:0] pc;                             // Next address to fetch.
    logic [pcWidth-1:0] reqPc;                          // Address of the open request.
    logic outstanding;
    logic stale;                                        // Open request is on a dead path.
    logic redirect;

    assign redirect = hz.flushF2 && (hz.branchM || hz.excpM || hz.excpW);

    assign hz.iWait = outstanding && !imemValid;

    // One request at a time, none on a redirect cycle.
    assign imemReq = !outstanding && !hz.stallF && !redirect;
    assign imemAddr = pc;

    assign q.push = imemValid && !hz.flushF2 && !stale;
    assign q.pushEntry = {reqPc, imemData};

    always_ff @(posedge clk) begin
        if (!rstN) begin
            pc <= '0;
            outstanding <= 1'b0;
            stale <= 1'b0;
        end else begin
            if (redirect) begin
                pc <= redirectPc;
            end else if (imemReq) begin
                pc <= pc + pcWidth'(1);
            end

            if (imemReq) begin
                outstanding <= 1'b1;
            end else if (imemValid) begin
                outstanding <= 1'b0;
            end

            if (redirect && hz.iWait) begin
                stale <= 1'b1;                          // Answer still on its way.
            end else if (imemValid) begin
                stale <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (imemReq) begin
            reqPc <= pc;
        end
    end
endmodule

// ==== verilog/hazardCtrl.sv ====
module hazardCtrl (
    input logic clk,
    input logic rstN,
    hazardIf.ctrl hz
);
    logic branchPending;                                // Taken branch met an open fetch.
    logic branchPendingNxt;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            branchPending <= 1'b0;
        end else begin
            branchPending <= branchPendingNxt;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Fixed priority: exception, branch, dWait, eWait, overflow, iWait
    ////////////////////////////////////////////////////////////////////////////
    always_comb begin
        hz.stallF = 1'b0;
        hz.flushF2 = 1'b0;
        hz.stallD = 1'b0;
        hz.flushD = 1'b0;
        hz.flushQue = 1'b0;
        hz.stallE = 1'b0;
        hz.flushE = 1'b0;
        hz.flushM = 1'b0;
        hz.flushW = 1'b0;
        branchPendingNxt = branchPending;

        if (hz.excpM || hz.excpW) begin
            hz.flushF2 = 1'b1;
            hz.flushD = 1'b1;
            hz.flushQue = 1'b1;
            hz.flushE = 1'b1;
            hz.flushM = 1'b1;
            hz.flushW = hz.excpW;                       // Load error sits in W.
        end else if (hz.branchM) begin
            hz.flushF2 = 1'b1;
            hz.flushD = 1'b1;
            hz.flushQue = 1'b1;
            hz.flushE = 1'b1;
            hz.flushM = 1'b1;
            if (hz.iWait) begin
                hz.stallF = 1'b1;
                branchPendingNxt = 1'b1;                // Drop the late response.
            end
        end else if (hz.dWait) begin
            hz.stallF = 1'b1;
            hz.stallD = 1'b1;
            hz.stallE = 1'b1;
        end else if (hz.eWait) begin
            hz.stallF = 1'b1;
            hz.stallD = 1'b1;
            hz.stallE = 1'b1;
            hz.flushM = 1'b1;                           // Bubble into M.
        end else if (hz.overflowQ) begin
            hz.stallF = 1'b1;                           // Fetch only.
        end else if (hz.iWait) begin
            hz.stallF = 1'b1;
            hz.flushF2 = 1'b1;
        end

        // Stale fetch has returned, clear what it may have left behind.
        if (!(hz.iWait || hz.eWait) && branchPending) begin
            hz.flushF2 = 1'b1;
            hz.flushD = 1'b1;
            branchPendingNxt = 1'b0;
        end
    end
endmodule

// ==== verilog/instQueue.sv ====
module instQueue import pipePkg::*; (
    input logic clk,
    input logic rstN,
    queueIf.buffer q,
    hazardIf.exec hz
);
    queueEntry mem [queueDepth];
    logic [queuePtrWidth-1:0] wrPtr;
    logic [queuePtrWidth-1:0] rdPtr;
    logic [queuePtrWidth:0] count;
    logic doPush;
    logic doPop;

    assign doPush = q.push && (count < (queuePtrWidth + 1)'(queueDepth));
    assign doPop = q.pop && !q.empty;

    assign q.empty = (count == '0);
    assign q.overflow = (count >= (queuePtrWidth + 1)'(queueHighMark));
    assign q.popEntry = mem[rdPtr];

    always_ff @(posedge clk) begin
        if (!rstN) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else if (hz.flushQue) begin
            wrPtr <= '0;                                // Empty in one cycle.
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (doPush) begin
                wrPtr <= wrPtr + queuePtrWidth'(1);
            end
            if (doPop) begin
                rdPtr <= rdPtr + queuePtrWidth'(1);
            end
            case ({doPush, doPop})
                2'b10: count <= count + (queuePtrWidth + 1)'(1);
                2'b01: count <= count - (queuePtrWidth + 1)'(1);
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (doPush) begin
            mem[wrPtr] <= q.pushEntry;
        end
    end
endmodule

// ==== verilog/pipeCore.sv ====
module pipeCore import pipePkg::*; (
    input logic clk,
    input logic rstN,

    // Instruction memory.
    output logic imemReq,
    output logic [pcWidth-1:0] imemAddr,
    input logic imemValid,
    input logic [instWidth-1:0] imemData,

    // Data memory.
    output logic dmemReq,
    output logic [xlen-1:0] dmemAddr,
    input logic dmemValid,
    input logic [xlen-1:0] dmemData,
    input logic dmemErr,

    // Retire port.
    output logic retireValid,
    output logic [pcWidth-1:0] retirePc,
    output logic [regIdxWidth-1:0] retireRd,
    output logic [xlen-1:0] retireData,
    output logic retireWe,
    output logic trapTaken
);
    hazardIf hz ();
    queueIf q ();
    logic [pcWidth-1:0] redirectPc;                     // Branch target or trap vector.

    assign hz.overflowQ = q.overflow;

    hazardCtrl i_hazardCtrl (
        .clk(clk),
        .rstN(rstN),
        .hz(hz)
    );

    fetchUnit i_fetchUnit (
        .clk(clk),
        .rstN(rstN),
        .hz(hz),
        .q(q),
        .redirectPc(redirectPc),
        .imemReq(imemReq),
        .imemAddr(imemAddr),
        .imemValid(imemValid),
        .imemData(imemData)
    );

    instQueue i_instQueue (
        .clk(clk),
        .rstN(rstN),
        .q(q),
        .hz(hz)
    );

    execUnit i_execUnit (
        .clk(clk),
        .rstN(rstN),
        .hz(hz),
        .q(q),
        .redirectPc(redirectPc),
        .dmemReq(dmemReq),
        .dmemAddr(dmemAddr),
        .dmemValid(dmemValid),
        .dmemData(dmemData),
        .dmemErr(dmemErr),
        .retireValid(retireValid),
        .retirePc(retirePc),
        .retireRd(retireRd),
        .retireData(retireData),
        .retireWe(retireWe),
        .trapTaken(trapTaken)
    );
endmodule

// ==== verilog/pipeIfs.sv ====
interface hazardIf;
    // Requests.
    logic iWait;
    logic dWait;
    logic eWait;
    logic overflowQ;
    logic branchM;
    logic excpM;
    logic excpW;

    // Commands.
    logic stallF;
    logic flushF2;
    logic stallD;
    logic flushD;
    logic flushQue;
    logic stallE;
    logic flushE;
    logic flushM;
    logic flushW;

    modport ctrl (
        input iWait, dWait, eWait, overflowQ, branchM, excpM, excpW,
        output stallF, flushF2, stallD, flushD, flushQue, stallE, flushE, flushM, flushW
    );
    modport fetch (
        output iWait,
        input stallF, flushF2, branchM, excpM, excpW
    );
    modport exec (
        output dWait, eWait, branchM, excpM, excpW,
        input stallD, flushD, flushQue, stallE, flushE, flushM, flushW
    );
endinterface

interface queueIf import pipePkg::*; ();
    logic push;
    queueEntry pushEntry;
    logic pop;
    queueEntry popEntry;
    logic empty;
    logic overflow;                                     // Level, occupancy at the high mark.

    modport producer (output push, pushEntry);
    modport buffer (input push, pushEntry, pop, output popEntry, empty, overflow);
    modport consumer (output pop, input popEntry, empty);
endinterface

// ==== verilog/pipePkg.sv ====
package pipePkg;

    ////////////////////////////////////////////////////////////////////////////
    // Widths and sizes
    ////////////////////////////////////////////////////////////////////////////
    localparam int xlen = 16;                           // Data and register width.
    localparam int pcWidth = 16;                        // Word addresses.
    localparam int instWidth = 16;
    localparam int regCount = 8;
    localparam int regIdxWidth = $clog2(regCount);
    localparam int queueDepth = 8;
    localparam int queuePtrWidth = $clog2(queueDepth);
    localparam int queueHighMark = 6;                   // Leaves room for one fetch in flight.
    localparam int mulLatency = 3;                      // Cycles a MUL holds E.
    localparam int mulCntWidth = $clog2(mulLatency);

    localparam logic [pcWidth-1:0] trapVector = 16'h00F0;

    ////////////////////////////////////////////////////////////////////////////
    // Opcodes, anything else is illegal
    ////////////////////////////////////////////////////////////////////////////
    localparam logic [3:0] opAddi = 4'h1;               // rd = rs + imm.
    localparam logic [3:0] opAdd = 4'h2;                // rd = rs + r[imm[2:0]].
    localparam logic [3:0] opMul = 4'h3;                // rd = rs * r[imm[2:0]].
    localparam logic [3:0] opLoad = 4'h4;               // rd = mem[rs + imm].
    localparam logic [3:0] opBeqz = 4'h5;               // if rs == 0, pc += 1 + offset.

    typedef struct packed {
        logic [3:0] opcode;
        logic [regIdxWidth-1:0] rd;
        logic [regIdxWidth-1:0] rs;
        logic [5:0] imm;
    } aluFmt;

    typedef struct packed {
        logic [3:0] opcode;
        logic [regIdxWidth-1:0] rs;
        logic [8:0] offset;                             // Signed, in words.
    } brFmt;

    typedef union packed {
        aluFmt alu;
        brFmt br;
    } instWord;

    typedef struct packed {
        logic [pcWidth-1:0] pc;
        instWord inst;
    } queueEntry;

endpackage
